//--- rtl/mpmc_pkg.sv
package mpmc_pkg;

	// ==============================
	// Channel and array geometry
	// ==============================

	// Eight requesters share the controller
	localparam int NUM_CH = 8;
	// Word addressing only, no byte lanes
	localparam int ADR_W = 8;
	localparam int DAT_W = 32;
	// The array covers the whole word address space
	localparam int MEM_WORDS = 256;

	// Word address into the shared array
	typedef logic [ADR_W-1:0] adr_t;

	// One data word, the only transfer size
	typedef logic [DAT_W-1:0] dat_t;

	// ==============================
	// Channel traffic
	// ==============================

	// A requester raises cs and holds every field until it sees ack
	typedef struct packed {
		logic cs;
		logic we;
		adr_t adr;
		dat_t dat;
	} ch_req_t;

	// Ack is a single cycle pulse; dat is only meaningful for reads
	typedef struct packed {
		logic ack;
		dat_t dat;
	} ch_rsp_t;

endpackage

//--- rtl/mpmc_seq_pkg.sv
package mpmc_seq_pkg;

	// ==============================
	// Sequencer states
	// ==============================

	// One arbitrated access walks all four states in order
	typedef enum logic [1:0] {
		IDLE,
		PRESET1,
		ACCESS,
		RESPOND
	} seq_state_t;

	// Channel number as chosen by the prioritizer
	typedef logic [3:0] ch_sel_t;

	// All ones marks an arbitration that found nobody
	localparam ch_sel_t CH_NONE = 4'hF;

	// The access performed in ACCESS and reported during RESPOND
	// For reads dat holds the word fetched from the array
	typedef struct packed {
		logic valid;
		ch_sel_t ch;
		logic we;
		mpmc_pkg::adr_t adr;
		mpmc_pkg::dat_t dat;
	} mem_cmd_t;

endpackage

//--- rtl/mpmc_tag_check.sv
`timescale 1ns/1ps

module mpmc_tag_check
	import mpmc_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  ch_req_t           req [NUM_CH],
	input  logic [NUM_CH-1:0] fill_en,
	input  dat_t              fill_dat,
	input  logic              inval_en,
	input  adr_t              inval_adr,
	output logic [NUM_CH-1:0] taghit,
	output dat_t              hit_dat [NUM_CH]
);

	// ==============================
	// One word line per channel
	// ==============================

	logic [NUM_CH-1:0] line_vld;
	adr_t              line_tag [NUM_CH];
	dat_t              line_dat [NUM_CH];

	// Set when a fill and an invalidate land on the same line together
	logic [NUM_CH-1:0] fill_conflict;

	// Valid bits are the only control state here
	// A fill sets the line of the channel that was just acked
	// An invalidate clears every line whose tag is the written address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			line_vld <= '0;
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (fill_en[i])
					line_vld[i] <= 1'b1;
				else if (inval_en && line_tag[i] == inval_adr)
					line_vld[i] <= 1'b0;
			end
		end
	end

	// Resp presents the completed access address on inval_adr for both kinds of update
	// so the tag of a fill is that address
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (fill_en[i]) begin
				line_tag[i] <= inval_adr;
				line_dat[i] <= fill_dat;
			end
		end
	end

	// Only reads can hit; a write always goes to arbitration
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			taghit[i]  = line_vld[i] && line_tag[i] == req[i].adr && !req[i].we;
			hit_dat[i] = line_dat[i];
		end
	end

	// A line filled with an address that is invalidated in the same cycle
	// would come out valid holding stale data
	always_comb begin
		for (int i = 0; i < NUM_CH; i++)
			fill_conflict[i] = fill_en[i] && inval_en;
	end

	a_fill_inval_excl : assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(fill_en) && fill_conflict == '0);

endmodule

//--- rtl/mpmc_ch_prioritize.sv
`timescale 1ns/1ps

module mpmc_ch_prioritize
	import mpmc_pkg::*;
	import mpmc_seq_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  seq_state_t        state,
	input  ch_req_t           req [NUM_CH],
	input  logic [NUM_CH-1:0] taghit,
	output ch_sel_t           ch
);

	// ==============================
	// Starvation guard
	// ==============================

	// Counts arbitrations; every 64th one raises elevate for the next
	logic [5:0] elevate_cnt;
	logic       elevate;

	// Writes and read misses that need the array this cycle
	logic [NUM_CH-1:0] wr_req;
	logic [NUM_CH-1:0] rd_miss;

	ch_sel_t ch_next;

	// Steps once per PRESET1, so one step per arbitration
	// Elevate stays up until the following PRESET1 clears it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			elevate_cnt <= '0;
			elevate     <= 1'b0;
		end else if (state == PRESET1) begin
			elevate_cnt <= elevate_cnt + 6'd1;
			elevate     <= elevate_cnt == 6'd63;
		end
	end

	// A read that hits its cache is answered by resp and never competes
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			wr_req[i]  = req[i].cs && req[i].we;
			rd_miss[i] = req[i].cs && !req[i].we && !taghit[i];
		end
	end

	// ==============================
	// Channel selection
	// ==============================

	// Each loop scans from the weakest claim up, so the last match wins
	always_comb begin
		ch_next = CH_NONE;
		if (elevate) begin
			// Reversed order: read misses 7 down to 0 sit below writes 7 down to 0
			for (int i = 0; i < NUM_CH; i++) begin
				if (rd_miss[i])
					ch_next = ch_sel_t'(i);
			end
			for (int i = 0; i < NUM_CH; i++) begin
				if (wr_req[i])
					ch_next = ch_sel_t'(i);
			end
		end else begin
			// Read misses on 1 to 7 rank lowest, lower channel first
			for (int i = NUM_CH - 1; i > 0; i--) begin
				if (rd_miss[i])
					ch_next = ch_sel_t'(i);
			end
			// Writes on 1 to 7 beat every read miss except channel 0
			for (int i = NUM_CH - 1; i > 0; i--) begin
				if (wr_req[i])
					ch_next = ch_sel_t'(i);
			end
			// Channel 0 goes first for either kind of access
			if (wr_req[0] || rd_miss[0])
				ch_next = '0;
		end
	end

	// Registered every clock; the sequencer uses the value taken in PRESET1
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ch <= CH_NONE;
		else
			ch <= ch_next;
	end

	// The channel that the sequencer serves in ACCESS must still be requesting
	a_sel_has_cs : assert property (@(posedge clk) disable iff (!arst_n)
		(state == ACCESS && ch != CH_NONE) |-> ch < ch_sel_t'(NUM_CH) && req[ch[2:0]].cs);

endmodule

//--- rtl/mpmc_sequencer.sv
`timescale 1ns/1ps

module mpmc_sequencer
	import mpmc_pkg::*;
	import mpmc_seq_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  ch_req_t           req [NUM_CH],
	input  logic [NUM_CH-1:0] taghit,
	input  ch_sel_t           ch,
	output seq_state_t        state,
	output mem_cmd_t          cmd
);

	// ==============================
	// Array and request decode
	// ==============================

	dat_t mem [MEM_WORDS];

	// Channels that need an array access rather than a cache answer
	logic [NUM_CH-1:0] pending;

	// Request of the channel named by the prioritizer
	ch_req_t sel_req;
	logic    sel_vld;

	// Completed access reported to resp for one cycle
	logic    cmd_valid;
	ch_sel_t cmd_ch;
	logic    cmd_we;
	adr_t    cmd_adr;
	dat_t    cmd_dat;

	always_comb begin
		for (int i = 0; i < NUM_CH; i++)
			pending[i] = req[i].cs && (req[i].we || !taghit[i]);
	end

	// Only the low three bits matter once CH_NONE is ruled out
	assign sel_req = req[ch[2:0]];
	assign sel_vld = ch != CH_NONE;

	// ==============================
	// State machine
	// ==============================

	// IDLE waits for work, PRESET1 lets the prioritizer settle on ch,
	// ACCESS touches the array and RESPOND carries the ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			unique case (state)
				IDLE:    if (|pending) state <= PRESET1;
				PRESET1: state <= ACCESS;
				// Nobody left to serve means no ack and a straight return to IDLE
				ACCESS:  state <= sel_vld ? RESPOND : IDLE;
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// The array comes up all zero and is written at the end of ACCESS
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem <= '{default: '0};
		else if (state == ACCESS && sel_vld && sel_req.we)
			mem[sel_req.adr] <= sel_req.dat;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= state == ACCESS && sel_vld;
	end

	// Latch the chosen request; reads pick up the word before any write lands
	always_ff @(posedge clk) begin
		if (state == ACCESS) begin
			cmd_ch  <= ch;
			cmd_we  <= sel_req.we;
			cmd_adr <= sel_req.adr;
			cmd_dat <= sel_req.we ? sel_req.dat : mem[sel_req.adr];
		end
	end

	assign cmd = '{
		valid: cmd_valid,
		ch:    cmd_ch,
		we:    cmd_we,
		adr:   cmd_adr,
		dat:   cmd_dat
	};

	// A reported command sits in RESPOND and names a real channel
	// because the access above used only ch[2:0]
	a_cmd_in_respond : assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> state == RESPOND && cmd_ch < ch_sel_t'(NUM_CH));

endmodule

//--- rtl/mpmc_resp.sv
`timescale 1ns/1ps

module mpmc_resp
	import mpmc_pkg::*;
	import mpmc_seq_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  ch_req_t           req [NUM_CH],
	input  logic [NUM_CH-1:0] taghit,
	input  dat_t              hit_dat [NUM_CH],
	input  mem_cmd_t          cmd,
	output ch_rsp_t           rsp [NUM_CH],
	output logic [NUM_CH-1:0] fill_en,
	output dat_t              fill_dat,
	output logic              inval_en,
	output adr_t              inval_adr
);

	// One bit per channel named by the current command
	logic [NUM_CH-1:0] cmd_sel;

	// Cache hit path, one register stage from the sampled request
	logic [NUM_CH-1:0] hit_ack_d;
	logic [NUM_CH-1:0] hit_ack_q;
	dat_t              hit_dat_q [NUM_CH];

	// Combined ack per channel
	logic [NUM_CH-1:0] ack_vec;

	// A hit on an address that is being invalidated right now is left
	// for the miss path, so it never returns a word older than the write
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			cmd_sel[i]   = cmd.valid && cmd.ch == ch_sel_t'(i);
			hit_ack_d[i] = req[i].cs && taghit[i] && !cmd_sel[i] && !hit_ack_q[i]
				&& !(inval_en && inval_adr == req[i].adr);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hit_ack_q <= '0;
		else
			hit_ack_q <= hit_ack_d;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (hit_ack_d[i])
				hit_dat_q[i] <= hit_dat[i];
		end
	end

	// ==============================
	// Channel responses
	// ==============================

	// Command acks come straight off the registered cmd so they line up with RESPOND
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			ack_vec[i]  = hit_ack_q[i] || cmd_sel[i];
			rsp[i].ack = ack_vec[i];
			rsp[i].dat = cmd_sel[i] ? cmd.dat : hit_dat_q[i];
		end
	end

	// A finished read loads its own channel's line
	assign fill_en  = cmd.we ? '0 : cmd_sel;
	assign fill_dat = cmd.dat;

	// A finished write drops the address from every channel's line
	assign inval_en  = cmd.valid && cmd.we;
	assign inval_adr = cmd.adr;

	// Requesters drop cs in the ack cycle, so a second ack right behind
	// the first would answer a request that was never made
	a_no_double_ack : assert property (@(posedge clk) disable iff (!arst_n)
		(|ack_vec) |=> (ack_vec & $past(ack_vec)) == '0);

endmodule

//--- rtl/mpmc_top.sv
`timescale 1ns/1ps

module mpmc_top
	import mpmc_pkg::*;
	import mpmc_seq_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  ch_req_t req [NUM_CH],
	output ch_rsp_t rsp [NUM_CH]
);

	// ==============================
	// Internal nets
	// ==============================

	// Decode results
	logic [NUM_CH-1:0] taghit;
	dat_t              hit_dat [NUM_CH];

	// Execute stage
	seq_state_t state;
	ch_sel_t    ch;
	mem_cmd_t   cmd;

	// Cache updates from the result stage
	logic [NUM_CH-1:0] fill_en;
	dat_t              fill_dat;
	logic              inval_en;
	adr_t              inval_adr;

	// Decode: per channel read cache lookup
	mpmc_tag_check i_tag_check (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.fill_en   (fill_en),
		.fill_dat  (fill_dat),
		.inval_en  (inval_en),
		.inval_adr (inval_adr),
		.taghit    (taghit),
		.hit_dat   (hit_dat)
	);

	// Execute: pick a channel, then run the access
	mpmc_ch_prioritize i_ch_prioritize (
		.clk    (clk),
		.arst_n (arst_n),
		.state  (state),
		.req    (req),
		.taghit (taghit),
		.ch     (ch)
	);

	mpmc_sequencer i_sequencer (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.taghit (taghit),
		.ch     (ch),
		.state  (state),
		.cmd    (cmd)
	);

	// Result: acks, read data and cache maintenance
	mpmc_resp i_resp (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.taghit    (taghit),
		.hit_dat   (hit_dat),
		.cmd       (cmd),
		.rsp       (rsp),
		.fill_en   (fill_en),
		.fill_dat  (fill_dat),
		.inval_en  (inval_en),
		.inval_adr (inval_adr)
	);

endmodule

//--- dv/tb_mpmc.sv
`timescale 1ns/1ps

module tb_mpmc
	import mpmc_pkg::*;
();

	// ==============================
	// Run limits
	// ==============================

	localparam int CLK_PERIOD  = 100;
	localparam int ACK_TIMEOUT = 16;

	// Array transactions issued by each test
	localparam int WRITE_READ_TXNS = 2;
	localparam int READ_HIT_TXNS   = 3;
	localparam int INVALIDATE_TXNS = 4;
	localparam int PRIORITY_TXNS   = 8;
	localparam int ELEVATE_TXNS    = 130;
	localparam int RANDOM_TXNS     = 200;

	// An arbitrated access takes four cycles plus one idle cycle between requests
	localparam int WATCHDOG_CYCLES = (WRITE_READ_TXNS + READ_HIT_TXNS + INVALIDATE_TXNS
		+ PRIORITY_TXNS + ELEVATE_TXNS + RANDOM_TXNS) * 8 + 16 + 200;

	logic    clk;
	logic    arst_n;
	ch_req_t req [NUM_CH];
	ch_rsp_t rsp [NUM_CH];

	// Reference model of the array and of every channel's one word cache
	dat_t              model_mem [MEM_WORDS];
	logic [NUM_CH-1:0] cache_vld;
	adr_t              cache_tag [NUM_CH];
	dat_t              cache_dat [NUM_CH];

	// Arbitrations since reset, counted from 1 like the elevate counter
	int          arb_count;
	int          error_count;
	logic [31:0] lfsr_state;

	mpmc_top i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.rsp    (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
		abort_run();
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("Error in %s: expected %0h, actual %0h", test_name, expected, actual);
			abort_run();
		end
	endtask

	// Galois LFSR, one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		end
		return value;
	endfunction

	// Apply one arbitrated access to the model
	// A read miss fills its own line, a write drops the address from every line
	task automatic model_commit(input int c, input logic we, input adr_t adr, input dat_t dat);
		arb_count++;
		if (we) begin
			model_mem[adr] = dat;
			for (int i = 0; i < NUM_CH; i++) begin
				if (cache_tag[i] == adr)
					cache_vld[i] = 1'b0;
			end
		end else begin
			cache_vld[c] = 1'b1;
			cache_tag[c] = adr;
			cache_dat[c] = model_mem[adr];
		end
	endtask

	// One request on an otherwise quiet controller
	// Hits answer one cycle after sampling, everything else three
	task automatic access_checked(input string test_name, input int c, input logic we,
		input adr_t adr, input dat_t dat);
		logic hit;
		dat_t exp_dat;
		int   exp_lat;
		int   lat;
		hit     = !we && cache_vld[c] && cache_tag[c] == adr;
		exp_dat = hit ? cache_dat[c] : model_mem[adr];
		exp_lat = hit ? 1 : 3;
		req[c]  = '{cs: 1'b1, we: we, adr: adr, dat: dat};
		lat     = 0;
		do begin
			@(negedge clk);
			lat++;
			if (lat > ACK_TIMEOUT) begin
				$display("No ack on channel %0d in %s within %0d cycles", c, test_name, ACK_TIMEOUT);
				abort_run();
			end
		end while (!rsp[c].ack);
		check_value({test_name, " latency"}, exp_lat, lat);
		if (!we)
			check_value({test_name, " read data"}, exp_dat, rsp[c].dat);
		req[c].cs = 1'b0;
		if (!hit)
			model_commit(c, we, adr, dat);
		// One idle cycle lets the sequencer settle back in IDLE
		@(negedge clk);
	endtask

	// Raise several array requests at once and check the grant order
	task automatic contend(input string test_name, input logic [NUM_CH-1:0] wr_mask,
		input logic [NUM_CH-1:0] rd_mask, input adr_t adr_base, input int order [$]);
		int idle;
		int exp_ch;
		for (int i = 0; i < NUM_CH; i++) begin
			if (wr_mask[i] || rd_mask[i])
				req[i] = '{cs: 1'b1, we: wr_mask[i], adr: adr_base + adr_t'(i), dat: rand_bits(32)};
		end
		idle = 0;
		while (order.size() > 0) begin
			@(negedge clk);
			idle++;
			if (idle > ACK_TIMEOUT) begin
				$display("%s stalled with %0d requests never acked", test_name, order.size());
				abort_run();
			end
			for (int i = 0; i < NUM_CH; i++) begin
				if (rsp[i].ack) begin
					idle = 0;
					if (order.size() > 0)
						exp_ch = order.pop_front();
					else
						exp_ch = -1;
					check_value({test_name, " grant order"}, exp_ch, i);
					if (!req[i].we)
						check_value({test_name, " read data"}, model_mem[req[i].adr], rsp[i].dat);
					model_commit(i, req[i].we, req[i].adr, req[i].dat);
					req[i].cs = 1'b0;
				end
			end
		end
		@(negedge clk);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_write_read();
		dat_t value;
		value = rand_bits(32);
		access_checked("test_write_read", 1, 1'b1, 8'h3c, value);
		// Channel 4 never saw this address so the read goes to the array
		access_checked("test_write_read", 4, 1'b0, 8'h3c, '0);
	endtask

	task automatic test_read_hit();
		access_checked("test_read_hit", 6, 1'b1, 8'h55, rand_bits(32));
		access_checked("test_read_hit", 3, 1'b0, 8'h55, '0);
		access_checked("test_read_hit", 3, 1'b0, 8'h55, '0);
	endtask

	task automatic test_invalidate();
		// First read returns the cleared array word and fills channel 2
		access_checked("test_invalidate", 2, 1'b0, 8'h66, '0);
		access_checked("test_invalidate", 2, 1'b0, 8'h66, '0);
		access_checked("test_invalidate", 5, 1'b1, 8'h66, rand_bits(32));
		access_checked("test_invalidate", 2, 1'b0, 8'h66, '0);
	endtask

	task automatic test_priority();
		int order [$];
		// Channel 0 read miss first, then writes 1 and 6, then read miss 3
		order = {0, 1, 6, 3};
		contend("test_priority", 8'b0100_0010, 8'b0000_1001, 8'ha0, order);
		// Writes on 4 and 7 beat read misses on 2 and 5
		order = {4, 7, 2, 5};
		contend("test_priority", 8'b1001_0000, 8'b0010_0100, 8'hb0, order);
	endtask

	task automatic test_elevate();
		int target;
		int pref;
		int acked;
		int idle;
		int grants_hi;
		target    = arb_count + 128;
		grants_hi = 0;
		idle      = 0;
		req[0] = '{cs: 1'b1, we: 1'b1, adr: 8'h10, dat: rand_bits(32)};
		req[7] = '{cs: 1'b1, we: 1'b1, adr: 8'h17, dat: rand_bits(32)};
		while (req[0].cs || req[7].cs) begin
			@(negedge clk);
			idle++;
			if (idle > ACK_TIMEOUT) begin
				$display("test_elevate got no grant for channel 0 or 7");
				abort_run();
			end
			if (rsp[0].ack || rsp[7].ack) begin
				idle  = 0;
				acked = rsp[7].ack ? 7 : 0;
				check_value("test_elevate single grant", 1, int'(rsp[0].ack) + int'(rsp[7].ack));
				model_commit(acked, 1'b1, req[acked].adr, req[acked].dat);
				// Arbitration 64k+1 runs in reversed order and favours channel 7
				pref = (arb_count % 64 == 1 && arb_count > 1) ? 7 : 0;
				if (!req[pref].cs)
					pref = 7 - pref;
				check_value("test_elevate grant", pref, acked);
				if (acked == 7 && req[0].cs)
					grants_hi++;
				req[acked].cs = 1'b0;
				@(negedge clk);
				if (arb_count < target)
					req[acked] = '{cs: 1'b1, we: 1'b1, adr: req[acked].adr, dat: rand_bits(32)};
			end
		end
		// 128 contested arbitrations hold exactly two elevated ones
		check_value("test_elevate channel 7 grants", 2, grants_hi);
		@(negedge clk);
	endtask

	task automatic test_random();
		int   c;
		logic we;
		adr_t adr;
		dat_t dat;
		for (int n = 0; n < RANDOM_TXNS; n++) begin
			c   = int'(rand_bits(3));
			we  = rand_bits(1) == 32'd1;
			// A narrow address range makes hits and invalidations common
			adr = adr_t'(rand_bits(3));
			dat = rand_bits(32);
			access_checked("test_random", c, we, adr, dat);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		lfsr_state  = 32'h84b23239;
		error_count = 0;
		arb_count   = 0;
		cache_vld   = '0;
		arst_n      = 1'b0;
		for (int i = 0; i < NUM_CH; i++) begin
			req[i]       = '0;
			cache_tag[i] = '0;
			cache_dat[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		test_write_read();
		test_read_hit();
		test_invalidate();
		test_priority();
		test_elevate();
		test_random();
		if (error_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- compile.f
rtl/mpmc_pkg.sv
rtl/mpmc_seq_pkg.sv
rtl/mpmc_tag_check.sv
rtl/mpmc_ch_prioritize.sv
rtl/mpmc_sequencer.sv
rtl/mpmc_resp.sv
rtl/mpmc_top.sv
dv/tb_mpmc.sv

//--- Bender.yml
package:
  name: mpmc

sources:
  # Packages first, then the RTL tree bottom up
  - rtl/mpmc_pkg.sv
  - rtl/mpmc_seq_pkg.sv
  - rtl/mpmc_tag_check.sv
  - rtl/mpmc_ch_prioritize.sv
  - rtl/mpmc_sequencer.sv
  - rtl/mpmc_resp.sv
  - rtl/mpmc_top.sv
  - target: test
    files:
      - dv/tb_mpmc.sv
